//--- source/quant_consts.svh
//--------------------------------------
// Quantizer constants for RTL and testbench
// Block size is fixed at 4x4 because the zigzag
// order is only defined for that size
// Table holds two matrices of 16 entries each,
// luma at 0..15 and chroma at 16..31
//--------------------------------------
`ifndef QUANT_CONSTS_SVH
`define QUANT_CONSTS_SVH

// Block geometry
`define QUANT_NCOEF      16
`define QUANT_CW         16

// Table memory
`define QUANT_TBL_DEPTH  32
`define QUANT_AW         5

// Entry field widths
`define QUANT_QW         16
`define QUANT_IQW        16
`define QUANT_BIASW      32
`define QUANT_ZTW        32
`define QUANT_SHW        16

// Arithmetic
`define QUANT_MAX_LEVEL  2047
`define QUANT_SHIFT      17

`endif

//--- source/quant_pkg.sv
//--------------------------------------
// Shared types of the 4x4 quantizer
// All entry fields are unsigned, coefficients
// are two's complement
// Matrix and block arrays are in raster order,
// element 0 in the low bits
//--------------------------------------
`default_nettype none

`include "quant_consts.svh"

package quant_pkg;

    // One quantization table entry, 112 bits
    typedef struct packed {
        logic [`QUANT_QW-1:0]    q;
        logic [`QUANT_IQW-1:0]   iq;
        logic [`QUANT_BIASW-1:0] bias;
        logic [`QUANT_ZTW-1:0]   zthresh;
        logic [`QUANT_SHW-1:0]   sharpen;
    } quant_entry_t;

    // Sixteen entries, one per coefficient
    typedef quant_entry_t [`QUANT_NCOEF-1:0] quant_matrix_t;

    // Sixteen signed coefficients or levels
    typedef logic signed [`QUANT_NCOEF-1:0][`QUANT_CW-1:0] coef_blk_t;

    typedef struct packed {
        coef_blk_t levels;  // zigzag order
        coef_blk_t recon;   // raster order
        logic      nz;
    } quant_result_t;

    // Table memory request
    typedef struct packed {
        logic                 we;
        logic [`QUANT_AW-1:0] addr;
        quant_entry_t         wdata;
    } tbl_req_t;

endpackage

`default_nettype wire

//--- source/quant_table_mem.sv
//--------------------------------------
// Single-port quantization table memory
// Read data appears one cycle after en with
// we low and holds until the next read
// Contents are not cleared by reset
//--------------------------------------
`default_nettype none

`include "quant_consts.svh"

module quant_table_mem (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    en_i,
    input  wire quant_pkg::tbl_req_t     req_i,
    output quant_pkg::quant_entry_t      rdata_o
);
    import quant_pkg::*;

    quant_entry_t mem_q [`QUANT_TBL_DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (req_i.we) begin
                mem_q[req_i.addr] <= req_i.wdata;
            end else begin
                rdata_o <= mem_q[req_i.addr];
            end
        end
    end

    //--------------------------------------
    // Checks
    //--------------------------------------

    // An access with an unknown address would corrupt or misread an entry
    a_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        en_i |-> !$isunknown(req_i.addr)
    );

endmodule

`default_nettype wire

//--- source/quant_mem_arbiter.sv
//--------------------------------------
// Round-robin arbiter for the table memory
// Requester 0 is the host, 1 the fetch unit
// Four-phase req/ack on both sides, ack comes
// 2 cycles after grant
// Read data is valid only while ack is high
//--------------------------------------
`default_nettype none

`include "quant_consts.svh"

module quant_mem_arbiter (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cfg_req_i,
    input  wire quant_pkg::tbl_req_t        cfg_cmd_i,
    output logic                            cfg_ack_o,
    output quant_pkg::quant_entry_t         cfg_rdata_o,
    input  wire logic                       fch_req_i,
    input  wire logic [`QUANT_AW-1:0]       fch_addr_i,
    output logic                            fch_ack_o,
    output quant_pkg::quant_entry_t         fch_rdata_o,
    output logic                            mem_en_o,
    output quant_pkg::tbl_req_t             mem_req_o,
    input  wire quant_pkg::quant_entry_t    mem_rdata_i
);
    import quant_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_wait,
        st_ack
    } arb_state_t;

    arb_state_t state_q;
    logic       grant_q;    // also the last-served pointer
    logic       grant_d;
    logic       gnt_req;
    tbl_req_t   fch_cmd;

    // Last-served side yields on a tie
    assign grant_d = (cfg_req_i && fch_req_i) ? !grant_q : fch_req_i;
    assign gnt_req = grant_q ? fch_req_i : cfg_req_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            grant_q <= 1'b1;
        end else begin
            case (state_q)
                st_idle: begin
                    if (cfg_req_i || fch_req_i) begin
                        grant_q <= grant_d;
                        state_q <= st_access;
                    end
                end
                st_access: state_q <= st_wait;
                st_wait:   state_q <= st_ack;
                st_ack: begin
                    if (!gnt_req) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Fetch side only ever reads
    assign fch_cmd = '{we: 1'b0, addr: fch_addr_i, wdata: '0};

    assign mem_en_o  = (state_q == st_access);
    assign mem_req_o = grant_q ? fch_cmd : cfg_cmd_i;

    assign cfg_ack_o   = (state_q == st_ack) && !grant_q;
    assign fch_ack_o   = (state_q == st_ack) && grant_q;
    assign cfg_rdata_o = mem_rdata_i;
    assign fch_rdata_o = mem_rdata_i;

    //--------------------------------------
    // Checks
    //--------------------------------------

    // Granted side keeps asking until its ack
    a_served_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == st_access || state_q == st_wait) |-> gnt_req
    );

    // Served command stays put until its data returns
    a_grant_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == st_access) |=> $stable(mem_req_o)
    );

endmodule

`default_nettype wire

//--- source/quant_matrix_fetch.sv
//--------------------------------------
// Block sequencer
// Fetches the selected matrix entry by entry
// through the arbiter, then runs the quantizer
// One block at a time; the matrix is fetched
// again for every block
//--------------------------------------
`default_nettype none

`include "quant_consts.svh"

module quant_matrix_fetch (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       blk_req_i,
    input  wire quant_pkg::coef_blk_t       blk_coef_i,
    input  wire logic                       blk_sel_i,
    output logic                            blk_ack_o,
    output quant_pkg::quant_result_t        blk_res_o,
    output logic                            fch_req_o,
    output logic [`QUANT_AW-1:0]            fch_addr_o,
    input  wire logic                       fch_ack_i,
    input  wire quant_pkg::quant_entry_t    fch_rdata_i,
    output logic                            start_o,
    output quant_pkg::coef_blk_t            coef_o,
    output quant_pkg::quant_matrix_t        mat_o,
    input  wire logic                       done_i,
    input  wire quant_pkg::quant_result_t   res_i
);
    import quant_pkg::*;

    localparam int idx_w = $clog2(`QUANT_NCOEF);
    localparam logic [idx_w-1:0] idx_last = idx_w'(`QUANT_NCOEF - 1);

    typedef enum logic [2:0] {
        fs_idle,
        fs_req,
        fs_rel,
        fs_start,
        fs_wait,
        fs_ack
    } fch_state_t;

    fch_state_t       state_q;
    logic [idx_w-1:0] idx_q;
    logic             sel_q;
    coef_blk_t        coef_q;
    quant_matrix_t    mat_q;
    quant_result_t    res_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fs_idle;
            idx_q   <= '0;
            res_q   <= '0;
        end else begin
            case (state_q)
                // Req can only be high here as a fresh request
                fs_idle: begin
                    if (blk_req_i) begin
                        idx_q   <= '0;
                        state_q <= fs_req;
                    end
                end
                fs_req: begin
                    if (fch_ack_i) begin
                        state_q <= fs_rel;
                    end
                end
                fs_rel: begin
                    if (!fch_ack_i) begin
                        if (idx_q == idx_last) begin
                            state_q <= fs_start;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            state_q <= fs_req;
                        end
                    end
                end
                fs_start: state_q <= fs_wait;
                fs_wait: begin
                    if (done_i) begin
                        res_q   <= res_i;
                        state_q <= fs_ack;
                    end
                end
                fs_ack: begin
                    if (!blk_req_i) begin
                        state_q <= fs_idle;
                    end
                end
                default: state_q <= fs_idle;
            endcase
        end
    end

    // Block operands and assembled matrix
    always_ff @(posedge clk) begin
        if (state_q == fs_idle && blk_req_i) begin
            coef_q <= blk_coef_i;
            sel_q  <= blk_sel_i;
        end
        if (state_q == fs_req && fch_ack_i) begin
            mat_q[idx_q] <= fch_rdata_i;
        end
    end

    assign fch_req_o  = (state_q == fs_req);
    assign fch_addr_o = {sel_q, idx_q};
    assign start_o    = (state_q == fs_start);
    assign coef_o     = coef_q;
    assign mat_o      = mat_q;
    assign blk_ack_o  = (state_q == fs_ack);
    assign blk_res_o  = res_q;

    //--------------------------------------
    // Checks
    //--------------------------------------

    // Arbiter acks only the outstanding read
    a_ack_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        fch_ack_i |-> (state_q == fs_req || state_q == fs_rel)
    );

endmodule

`default_nettype wire

//--- source/quant_block.sv
//--------------------------------------
// Two-stage parallel quantizer, 16 coefficients
// done_o follows start_i by exactly 2 cycles
// Accepts a new start every cycle
// Sign is taken per coefficient
// Reconstruction is truncated to 16 bits
//--------------------------------------
`default_nettype none

`include "quant_consts.svh"

module quant_block (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       start_i,
    input  wire quant_pkg::coef_blk_t       coef_i,
    input  wire quant_pkg::quant_matrix_t   mat_i,
    output logic                            done_o,
    output quant_pkg::quant_result_t        res_o
);
    import quant_pkg::*;

    localparam int zz_order [`QUANT_NCOEF] = '{
        0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15
    };

    // Stage one combinational
    logic [`QUANT_CW:0]    cext  [`QUANT_NCOEF];
    logic [`QUANT_CW:0]    mag   [`QUANT_NCOEF];
    logic [31:0]           magsh [`QUANT_NCOEF];
    logic [63:0]           acc   [`QUANT_NCOEF];

    // Stage one registers
    logic [31:0]           lvl_q  [`QUANT_NCOEF];
    logic                  neg_q  [`QUANT_NCOEF];
    logic                  keep_q [`QUANT_NCOEF];
    logic [`QUANT_QW-1:0]  q_q    [`QUANT_NCOEF];

    // Stage two combinational
    logic [`QUANT_CW-1:0]  lvl_clip [`QUANT_NCOEF];
    logic [`QUANT_CW-1:0]  lvl_sgn  [`QUANT_NCOEF];
    logic signed [32:0]    rec_full [`QUANT_NCOEF];

    coef_blk_t             lev_q;
    coef_blk_t             rec_q;
    coef_blk_t             lev_zz;
    logic [1:0]            vld_q;

    //--------------------------------------
    // Stage one: magnitude, scale, bias
    //--------------------------------------
    always_comb begin
        for (int i = 0; i < `QUANT_NCOEF; i++) begin
            cext[i]  = {coef_i[i][`QUANT_CW-1], coef_i[i]};
            mag[i]   = cext[i][`QUANT_CW] ? (17'd0 - cext[i]) : cext[i];
            magsh[i] = 32'(mag[i]) + 32'(mat_i[i].sharpen);
            // Fits well inside 64 bits, so the shift is exact
            acc[i]   = 64'(magsh[i]) * 64'(mat_i[i].iq) + 64'(mat_i[i].bias);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `QUANT_NCOEF; i++) begin
            lvl_q[i]  <= acc[i][`QUANT_SHIFT +: 32];
            neg_q[i]  <= cext[i][`QUANT_CW];
            keep_q[i] <= magsh[i] > mat_i[i].zthresh;
            q_q[i]    <= mat_i[i].q;
        end
    end

    //--------------------------------------
    // Stage two: clip, sign, dead zone, recon
    //--------------------------------------
    always_comb begin
        for (int i = 0; i < `QUANT_NCOEF; i++) begin
            if (lvl_q[i] > 32'(`QUANT_MAX_LEVEL)) begin
                lvl_clip[i] = 16'(`QUANT_MAX_LEVEL);
            end else begin
                lvl_clip[i] = lvl_q[i][`QUANT_CW-1:0];
            end
            if (!keep_q[i]) begin
                lvl_sgn[i] = '0;
            end else if (neg_q[i]) begin
                lvl_sgn[i] = 16'd0 - lvl_clip[i];
            end else begin
                lvl_sgn[i] = lvl_clip[i];
            end
            rec_full[i] = $signed(lvl_sgn[i]) * $signed({1'b0, q_q[i]});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lev_q <= '0;
            rec_q <= '0;
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[0], start_i};
            for (int i = 0; i < `QUANT_NCOEF; i++) begin
                lev_q[i] <= lvl_sgn[i];
                rec_q[i] <= rec_full[i][`QUANT_CW-1:0];
            end
        end
    end

    // Levels leave in zigzag order
    always_comb begin
        for (int k = 0; k < `QUANT_NCOEF; k++) begin
            lev_zz[k] = lev_q[zz_order[k]];
        end
    end

    assign done_o = vld_q[1];
    assign res_o  = '{levels: lev_zz, recon: rec_q, nz: |lev_q};

endmodule

`default_nettype wire

//--- source/quant_top.sv
//--------------------------------------
// 4x4 coefficient quantizer top level
// Host port writes and reads the matrix table,
// block port quantizes one block at a time
// Both ports use four-phase req/ack
// Matrix 0 is luma, matrix 1 chroma
//--------------------------------------
`default_nettype none

`include "quant_consts.svh"

module quant_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cfg_req_i,
    input  wire quant_pkg::tbl_req_t        cfg_cmd_i,
    output wire logic                       cfg_ack_o,
    output wire quant_pkg::quant_entry_t    cfg_rdata_o,
    input  wire logic                       blk_req_i,
    input  wire quant_pkg::coef_blk_t       blk_coef_i,
    input  wire logic                       blk_sel_i,
    output wire logic                       blk_ack_o,
    output wire quant_pkg::quant_result_t   blk_res_o
);
    import quant_pkg::*;

    // Fetch unit to arbiter
    logic                 fch_req;
    logic [`QUANT_AW-1:0] fch_addr;
    logic                 fch_ack;
    quant_entry_t         fch_rdata;

    // Arbiter to memory
    logic                 mem_en;
    tbl_req_t             mem_req;
    quant_entry_t         mem_rdata;

    // Fetch unit to quantizer
    logic                 q_start;
    coef_blk_t            q_coef;
    quant_matrix_t        q_mat;
    logic                 q_done;
    quant_result_t        q_res;

    quant_table_mem u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .en_i    (mem_en),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

    quant_mem_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_req_i   (cfg_req_i),
        .cfg_cmd_i   (cfg_cmd_i),
        .cfg_ack_o   (cfg_ack_o),
        .cfg_rdata_o (cfg_rdata_o),
        .fch_req_i   (fch_req),
        .fch_addr_i  (fch_addr),
        .fch_ack_o   (fch_ack),
        .fch_rdata_o (fch_rdata),
        .mem_en_o    (mem_en),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata)
    );

    quant_matrix_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_req_i   (blk_req_i),
        .blk_coef_i  (blk_coef_i),
        .blk_sel_i   (blk_sel_i),
        .blk_ack_o   (blk_ack_o),
        .blk_res_o   (blk_res_o),
        .fch_req_o   (fch_req),
        .fch_addr_o  (fch_addr),
        .fch_ack_i   (fch_ack),
        .fch_rdata_i (fch_rdata),
        .start_o     (q_start),
        .coef_o      (q_coef),
        .mat_o       (q_mat),
        .done_i      (q_done),
        .res_i       (q_res)
    );

    quant_block u_quant (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (q_start),
        .coef_i  (q_coef),
        .mat_i   (q_mat),
        .done_o  (q_done),
        .res_o   (q_res)
    );

endmodule

`default_nettype wire

//--- dv/quant_checker.sv
//--------------------------------------
// Port monitor and reference model
// Shadow table is built from host writes
// seen at cfg_ack rise, so reads of entries
// never written compare against zero
// Block result is checked at blk_ack rise
//--------------------------------------
`default_nettype none

`include "quant_consts.svh"

module quant_checker (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire quant_pkg::tbl_req_t        cfg_cmd_i,
    input  wire logic                       cfg_ack_i,
    input  wire quant_pkg::quant_entry_t    cfg_rdata_i,
    input  wire logic                       blk_req_i,
    input  wire quant_pkg::coef_blk_t       blk_coef_i,
    input  wire logic                       blk_sel_i,
    input  wire logic                       blk_ack_i,
    input  wire quant_pkg::quant_result_t   blk_res_i,
    output int                              err_cnt_o,
    output int                              chk_cnt_o
);
    import quant_pkg::*;

    localparam int zz_order [`QUANT_NCOEF] = '{
        0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15
    };

    quant_entry_t  shadow [`QUANT_TBL_DEPTH];
    logic          cfg_ack_d = 1'b0;
    logic          blk_ack_d = 1'b0;
    logic          blk_req_d = 1'b0;
    quant_result_t res_d = '0;
    int            n_err = 0;
    int            n_chk = 0;

    initial begin
        for (int a = 0; a < `QUANT_TBL_DEPTH; a++) begin
            shadow[a] = '0;
        end
    end

    //--------------------------------------
    // Reference quantizer
    //--------------------------------------
    function automatic quant_result_t expected_result(input coef_blk_t coef,
                                                      input quant_matrix_t mat);
        quant_result_t r;
        coef_blk_t     lev_raster;
        longint        c;
        longint        mag;
        longint        magsh;
        longint        lvl;
        longint        lev;
        longint        rec;
        r = '0;
        lev_raster = '0;
        for (int i = 0; i < `QUANT_NCOEF; i++) begin
            c     = longint'($signed(coef[i]));
            mag   = (c < 0) ? -c : c;
            magsh = mag + longint'(mat[i].sharpen);
            lvl   = (magsh * longint'(mat[i].iq) + longint'(mat[i].bias)) >> `QUANT_SHIFT;
            if (lvl > longint'(`QUANT_MAX_LEVEL)) begin
                lvl = longint'(`QUANT_MAX_LEVEL);
            end
            // Dead zone
            if (magsh <= longint'(mat[i].zthresh)) begin
                lev = 0;
            end else if (c < 0) begin
                lev = -lvl;
            end else begin
                lev = lvl;
            end
            rec = lev * longint'(mat[i].q);
            lev_raster[i] = lev[15:0];
            r.recon[i]    = rec[15:0];
        end
        for (int k = 0; k < `QUANT_NCOEF; k++) begin
            r.levels[k] = lev_raster[zz_order[k]];
        end
        r.nz = (lev_raster != '0);
        return r;
    endfunction

    task automatic compare_block();
        quant_matrix_t m;
        quant_result_t e;
        for (int i = 0; i < `QUANT_NCOEF; i++) begin
            m[i] = shadow[{blk_sel_i, 4'(i)}];
        end
        e = expected_result(blk_coef_i, m);
        n_chk++;
        for (int k = 0; k < `QUANT_NCOEF; k++) begin
            if (blk_res_i.levels[k] !== e.levels[k]) begin
                n_err++;
                $display("ERR blk_res_o.levels[%0d] exp=%h got=%h",
                         k, e.levels[k], blk_res_i.levels[k]);
            end
            if (blk_res_i.recon[k] !== e.recon[k]) begin
                n_err++;
                $display("ERR blk_res_o.recon[%0d] exp=%h got=%h",
                         k, e.recon[k], blk_res_i.recon[k]);
            end
        end
        if (blk_res_i.nz !== e.nz) begin
            n_err++;
            $display("ERR blk_res_o.nz exp=%h got=%h", e.nz, blk_res_i.nz);
        end
    endtask

    //--------------------------------------
    // Port watch
    //--------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            if (cfg_ack_i || blk_ack_i) begin
                n_err++;
                $display("an ack output was high during reset");
            end
            if (blk_res_i !== '0) begin
                n_err++;
                $display("ERR blk_res_o exp=0 got=%h during reset", blk_res_i);
            end
        end else begin
            // Host access completes on ack rise
            if (cfg_ack_i && !cfg_ack_d) begin
                if (cfg_cmd_i.we) begin
                    shadow[cfg_cmd_i.addr] = cfg_cmd_i.wdata;
                end else begin
                    n_chk++;
                    if (cfg_rdata_i !== shadow[cfg_cmd_i.addr]) begin
                        n_err++;
                        $display("ERR cfg_rdata_o addr=%h exp=%h got=%h",
                                 cfg_cmd_i.addr, shadow[cfg_cmd_i.addr], cfg_rdata_i);
                    end
                end
            end
            if (blk_ack_i && !blk_ack_d) begin
                compare_block();
            end
            if (blk_ack_i && blk_ack_d && blk_res_i !== res_d) begin
                n_err++;
                $display("ERR blk_res_o changed under ack exp=%h got=%h", res_d, blk_res_i);
            end
            if (!blk_ack_i && blk_ack_d && blk_req_d) begin
                n_err++;
                $display("blk_ack_o fell while blk_req_i was still high");
            end
        end
        cfg_ack_d = cfg_ack_i;
        blk_ack_d = blk_ack_i;
        blk_req_d = blk_req_i;
        res_d     = blk_res_i;
    end

    assign err_cnt_o = n_err;
    assign chk_cnt_o = n_chk;

endmodule

`default_nettype wire

//--- dv/quant_tb.sv
//--------------------------------------
// Testbench for the 4x4 quantizer
// Inputs change 2 time units after the rising
// clock edge, outputs are read at that point too
// Block rows with host traffic write only the
// matrix that the block does not use
//--------------------------------------
`default_nettype none

`include "quant_consts.svh"

module quant_tb;
    import quant_pkg::*;

    localparam int clk_period = 40;
    localparam int drive_dly  = 2;
    localparam int ack_hold   = 3;

    // Row operations
    localparam logic [1:0] op_wr   = 2'd0;
    localparam logic [1:0] op_rd   = 2'd1;
    localparam logic [1:0] op_blk  = 2'd2;
    localparam logic [1:0] op_blkw = 2'd3;

    // Pattern codes
    localparam logic [1:0] pat_rnd   = 2'd0;
    localparam logic [1:0] pat_zero  = 2'd1;
    localparam logic [1:0] pat_large = 2'd2;
    localparam logic [1:0] pat_near  = 2'd3;

    typedef struct packed {
        logic [1:0] op;
        logic       sel;
        logic [1:0] pat;
    } stim_row_t;

    localparam int n_rows      = 19;
    localparam int cycle_limit = n_rows * 120 + 200;

    localparam stim_row_t stim_tbl [n_rows] = '{
        '{op_wr,   1'b0, pat_rnd},
        '{op_wr,   1'b1, pat_near},
        '{op_rd,   1'b0, pat_rnd},
        '{op_rd,   1'b1, pat_rnd},
        '{op_blk,  1'b0, pat_rnd},
        '{op_blk,  1'b1, pat_near},
        '{op_blk,  1'b0, pat_zero},
        '{op_blk,  1'b1, pat_rnd},
        '{op_wr,   1'b0, pat_large},
        '{op_wr,   1'b1, pat_rnd},
        '{op_rd,   1'b0, pat_rnd},
        '{op_blk,  1'b0, pat_large},
        '{op_blk,  1'b1, pat_zero},
        '{op_blkw, 1'b0, pat_rnd},
        '{op_blkw, 1'b1, pat_rnd},
        '{op_rd,   1'b0, pat_rnd},
        '{op_rd,   1'b1, pat_rnd},
        '{op_wr,   1'b0, pat_near},
        '{op_blk,  1'b0, pat_near}
    };

    logic          clk;
    logic          rst_n;
    logic          cfg_req;
    tbl_req_t      cfg_cmd;
    logic          cfg_ack;
    quant_entry_t  cfg_rdata;
    logic          blk_req;
    coef_blk_t     blk_coef;
    logic          blk_sel;
    logic          blk_ack;
    quant_result_t blk_res;
    logic [31:0]   rng_q;
    int            cycle_cnt = 0;
    int            err_cnt;
    int            chk_cnt;

    quant_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_req_i   (cfg_req),
        .cfg_cmd_i   (cfg_cmd),
        .cfg_ack_o   (cfg_ack),
        .cfg_rdata_o (cfg_rdata),
        .blk_req_i   (blk_req),
        .blk_coef_i  (blk_coef),
        .blk_sel_i   (blk_sel),
        .blk_ack_o   (blk_ack),
        .blk_res_o   (blk_res)
    );

    quant_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_cmd_i   (cfg_cmd),
        .cfg_ack_i   (cfg_ack),
        .cfg_rdata_i (cfg_rdata),
        .blk_req_i   (blk_req),
        .blk_coef_i  (blk_coef),
        .blk_sel_i   (blk_sel),
        .blk_ack_i   (blk_ack),
        .blk_res_i   (blk_res),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //--------------------------------------
    // Stimulus generation
    //--------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_q = xorshift32(rng_q);
        return rng_q;
    endfunction

    function automatic quant_entry_t make_entry(input logic [1:0] pat);
        quant_entry_t e;
        logic [31:0]  r0;
        logic [31:0]  r1;
        logic [31:0]  r2;
        r0 = next_rand();
        r1 = next_rand();
        r2 = next_rand();
        e  = '0;
        case (pat)
            pat_rnd: begin
                e.q       = r0[15:0];
                e.iq      = r0[31:16];
                e.bias    = {15'd0, r1[16:0]};
                // Keeps zthresh above any sharpen
                e.zthresh = {22'd0, r2[9:0]} + 32'd32;
                e.sharpen = {11'd0, r2[20:16]};
            end
            pat_large: begin
                e.q       = r0[15:0];
                e.iq      = {8'hff, r0[23:16]};
                e.bias    = {15'd0, r1[16:0]};
                e.sharpen = {11'd0, r2[4:0]};
            end
            pat_near: begin
                e.q       = r0[15:0];
                e.iq      = {4'h2, r0[27:16]};
                e.bias    = {16'd0, r1[15:0]};
                e.zthresh = 32'd100;
                e.sharpen = {14'd0, r2[1:0]};
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    function automatic coef_blk_t make_coef(input logic [1:0] pat);
        coef_blk_t   c;
        logic [31:0] r;
        logic [15:0] m;
        for (int i = 0; i < `QUANT_NCOEF; i++) begin
            r = next_rand();
            case (pat)
                pat_zero:  m = '0;
                pat_large: m = {2'b01, r[13:0]};
                // Magnitudes 96 to 104 around a threshold of 100
                pat_near:  m = 16'd96 + {13'd0, r[2:0]} + {15'd0, r[3]};
                default:   m = r[15:0];
            endcase
            c[i] = r[16] ? (16'd0 - m) : m;
        end
        return c;
    endfunction

    //--------------------------------------
    // Port handshakes
    //--------------------------------------
    task automatic host_access(input tbl_req_t cmd);
        cfg_cmd = cmd;
        cfg_req = 1'b1;
        do begin
            @(posedge clk);
            #drive_dly;
        end while (!cfg_ack);
        cfg_req = 1'b0;
        do begin
            @(posedge clk);
            #drive_dly;
        end while (cfg_ack);
    endtask

    task automatic write_matrix(input logic sel, input logic [1:0] pat);
        tbl_req_t cmd;
        for (int i = 0; i < `QUANT_NCOEF; i++) begin
            cmd.we    = 1'b1;
            cmd.addr  = {sel, 4'(i)};
            cmd.wdata = make_entry(pat);
            host_access(cmd);
        end
    endtask

    task automatic read_matrix(input logic sel);
        tbl_req_t cmd;
        for (int i = 0; i < `QUANT_NCOEF; i++) begin
            cmd.we    = 1'b0;
            cmd.addr  = {sel, 4'(i)};
            cmd.wdata = '0;
            host_access(cmd);
        end
    endtask

    task automatic run_block(input logic sel, input logic [1:0] pat);
        blk_coef = make_coef(pat);
        blk_sel  = sel;
        blk_req  = 1'b1;
        do begin
            @(posedge clk);
            #drive_dly;
        end while (!blk_ack);
        // Caller holds req after the ack, result and ack must stay
        repeat (ack_hold) begin
            @(posedge clk);
            #drive_dly;
        end
        blk_req = 1'b0;
        do begin
            @(posedge clk);
            #drive_dly;
        end while (blk_ack);
    endtask

    //--------------------------------------
    // Main sequence
    //--------------------------------------
    initial begin
        cfg_req  = 1'b0;
        cfg_cmd  = '0;
        blk_req  = 1'b0;
        blk_coef = '0;
        blk_sel  = 1'b0;
        rng_q    = 32'h1079;
        rst_n    = 1'b1;
        #drive_dly rst_n = 1'b0;
        @(posedge clk);
        repeat (5) @(posedge clk);
        #drive_dly rst_n = 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            case (stim_tbl[r].op)
                op_wr:  write_matrix(stim_tbl[r].sel, stim_tbl[r].pat);
                op_rd:  read_matrix(stim_tbl[r].sel);
                op_blk: run_block(stim_tbl[r].sel, stim_tbl[r].pat);
                default: begin
                    // Host rewrites the other matrix while the block fetches
                    fork
                        run_block(stim_tbl[r].sel, stim_tbl[r].pat);
                        write_matrix(!stim_tbl[r].sel, pat_rnd);
                    join
                end
            endcase
        end

        repeat (4) @(posedge clk);
        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, a handshake never completed, %0d errors",
                     cycle_cnt, err_cnt);
            $display("tests failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- quant.f
+incdir+source
source/quant_pkg.sv
source/quant_table_mem.sv
source/quant_mem_arbiter.sv
source/quant_matrix_fetch.sv
source/quant_block.sv
source/quant_top.sv
dv/quant_checker.sv
dv/quant_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the quantizer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module quant_tb -f quant.f -o quant_sim

if ! ./obj_dir/quant_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi

exit 0
